/* src/ubaPkg.sv */
// Unibus adapter interrupt path
// Shared widths, status register field positions and acknowledge codes

package ubaPkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   // PI level number, 0 means no interrupt
   localparam int piWidth = 3;

   // One-hot bus interrupt for PI 1..7
   // Bit n-1 carries PI level n
   localparam int busIntrWidth = 7;

   // Device request lines 7..4
   // Bit 3 is line 7, bit 0 is line 4
   localparam int devCount = 4;

   // Device interrupt vector
   localparam int vectorWidth = 16;

   // Status register data word
   localparam int regWidth = 16;

   //////////////////////////////////////////////////////////////////////
   // Status register fields
   //////////////////////////////////////////////////////////////////////

   // Low group PI level, bits 2..0
   localparam int pilLsb = 0;

   // High group PI level, bits 5..3
   localparam int pihLsb = 3;

   // Read-only request status
   localparam int intLoBit = 6;
   localparam int intHiBit = 7;

   //////////////////////////////////////////////////////////////////////
   // Acknowledge codes
   //////////////////////////////////////////////////////////////////////

   // One-hot over lines 7..4, empty when nobody is acknowledged
   localparam logic [devCount-1:0] intaNone = 4'b0000;
   localparam logic [devCount-1:0] intaR7   = 4'b1000;
   localparam logic [devCount-1:0] intaR6   = 4'b0100;
   localparam logic [devCount-1:0] intaR5   = 4'b0010;
   localparam logic [devCount-1:0] intaR4   = 4'b0001;

endpackage : ubaPkg

/* src/ubaStatusReg.sv */
// Unibus adapter status register
// Holds the high and low group PI levels, reads back with live request status

`timescale 1ns/1ns

module ubaStatusReg
(
   input  logic                       clk,
   input  logic                       rst,
   // CPU side
   input  logic                       regWrite,
   input  logic [ubaPkg::regWidth-1:0] regWdata,
   output logic [ubaPkg::regWidth-1:0] regRdata,
   // Live request status from the interrupt block
   input  logic                       intHi,
   input  logic                       intLo,
   // Stored PI levels
   output logic [ubaPkg::piWidth-1:0]  piHigh,
   output logic [ubaPkg::piWidth-1:0]  piLow
);

   import ubaPkg::*;

   //////////////////////////////////////////////////////////////////////
   // PI level storage
   //////////////////////////////////////////////////////////////////////

   // Only the two PI fields are writable
   // Everything else in the write word is dropped
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         // No interrupt level assigned out of reset
         piHigh <= '0;
         piLow  <= '0;
      end
      else if (regWrite)
      begin
         piHigh <= regWdata[pihLsb +: piWidth];
         piLow  <= regWdata[pilLsb +: piWidth];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Readback word
   //////////////////////////////////////////////////////////////////////

   // Stored fields plus request status straight from the devices
   // Unused bits read as zero
   always_comb
   begin
      regRdata = '0;
      // PI fields
      regRdata[pilLsb +: piWidth] = piLow;
      regRdata[pihLsb +: piWidth] = piHigh;
      // Live status, not latched
      regRdata[intLoBit] = intLo;
      regRdata[intHiBit] = intHi;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Upper byte stays clear whatever the CPU wrote there
   aUpperClear : assert property (
      @(posedge clk) disable iff (rst)
      regRdata[regWidth-1:intHiBit+1] == '0
   )
   else
      $error("status readback has bits set above the INTHI bit");

endmodule : ubaStatusReg

/* src/ubaIntr.sv */
// Unibus adapter interrupt block
// Raises bus interrupt levels per group and acknowledges the WRU winner

`timescale 1ns/1ns

module ubaIntr
(
   input  logic                            clk,
   input  logic                            rst,
   // Device request levels, bit 3 is line 7
   input  logic [ubaPkg::devCount-1:0]     devIntr,
   // Group PI levels from the status register
   input  logic [ubaPkg::piWidth-1:0]      piHigh,
   input  logic [ubaPkg::piWidth-1:0]      piLow,
   // Group request status back to the register
   output logic                            intHi,
   output logic                            intLo,
   // One-hot interrupt to the bus
   output logic [ubaPkg::busIntrWidth-1:0] busIntr,
   // Who-are-you cycle
   input  logic                            wruRead,
   input  logic [ubaPkg::piWidth-1:0]      busPi,
   output logic [ubaPkg::devCount-1:0]     devInta
);

   import ubaPkg::*;

   logic [busIntrWidth-1:0] intrHigh;
   logic [busIntrWidth-1:0] intrLow;

   //////////////////////////////////////////////////////////////////////
   // Group request status
   //////////////////////////////////////////////////////////////////////

   // Lines 7 and 6 form the high group
   assign intHi = devIntr[3] | devIntr[2];
   // Lines 5 and 4 form the low group
   assign intLo = devIntr[1] | devIntr[0];

   //////////////////////////////////////////////////////////////////////
   // PI level decode
   //////////////////////////////////////////////////////////////////////

   // Level n sets bit n-1, level 0 gives nothing
   function automatic logic [busIntrWidth-1:0] piDecode(
      input logic [piWidth-1:0] level
   );
      logic [busIntrWidth-1:0] oneHot;
      oneHot = '0;
      if (level != '0)
      begin
         oneHot[level - 1'b1] = 1'b1;
      end
      return oneHot;
   endfunction

   // Each group only drives its level while it has a request
   assign intrHigh = intHi ? piDecode(piHigh) : '0;
   assign intrLow  = intLo ? piDecode(piLow) : '0;

   // Both groups may sit on the same level, OR merges them
   assign busIntr = intrHigh | intrLow;

   //////////////////////////////////////////////////////////////////////
   // WRU acknowledge
   //////////////////////////////////////////////////////////////////////

   // Served level is compared against the high group first
   // Within a group the higher line number wins
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         devInta <= intaNone;
      end
      else if (wruRead && (busPi == piHigh))
      begin
         if (devIntr[3])
            devInta <= intaR7;
         else if (devIntr[2])
            devInta <= intaR6;
         else
            devInta <= intaNone;
      end
      else if (wruRead && (busPi == piLow))
      begin
         if (devIntr[1])
            devInta <= intaR5;
         else if (devIntr[0])
            devInta <= intaR4;
         else
            devInta <= intaNone;
      end
      else
      begin
         // Acknowledge lasts a single cycle
         devInta <= intaNone;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // At most one device acknowledged at a time
   aIntaOneHot : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(devInta)
   )
   else
      $error("more than one device acknowledged");

   // No acknowledge without a WRU strobe on the cycle before
   aIntaNeedsWru : assert property (
      @(posedge clk) disable iff (rst)
      !wruRead |=> (devInta == intaNone)
   )
   else
      $error("acknowledge issued without a WRU strobe");

endmodule : ubaIntr

/* src/ubaVectorLatch.sv */
// Unibus adapter vector latch
// Captures the acknowledged device's vector and strobes it out

`timescale 1ns/1ns

module ubaVectorLatch
(
   input  logic                           clk,
   input  logic                           rst,
   // Acknowledge from the interrupt block
   input  logic [ubaPkg::devCount-1:0]    devInta,
   // Vectors for lines 4, 5, 6 and 7
   input  logic [ubaPkg::vectorWidth-1:0] devVector0,
   input  logic [ubaPkg::vectorWidth-1:0] devVector1,
   input  logic [ubaPkg::vectorWidth-1:0] devVector2,
   input  logic [ubaPkg::vectorWidth-1:0] devVector3,
   // Latched vector for the bus
   output logic [ubaPkg::vectorWidth-1:0] vecData,
   output logic                           vecValid
);

   import ubaPkg::*;

   logic [vectorWidth-1:0] vecSel;
   logic                   intaSeen;

   //////////////////////////////////////////////////////////////////////
   // Vector select
   //////////////////////////////////////////////////////////////////////

   assign intaSeen = (devInta != intaNone);

   // Acknowledge is one-hot, so a plain case picks the line
   always_comb
   begin
      case (devInta)
         intaR7:  vecSel = devVector3;
         intaR6:  vecSel = devVector2;
         intaR5:  vecSel = devVector1;
         intaR4:  vecSel = devVector0;
         default: vecSel = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Capture
   //////////////////////////////////////////////////////////////////////

   // Vector holds until the next acknowledge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         vecData <= '0;
      end
      else if (intaSeen)
      begin
         vecData <= vecSel;
      end
   end

   // One strobe per acknowledge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         vecValid <= 1'b0;
      else
         vecValid <= intaSeen;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Two strobes in a row need two acknowledges in a row before them
   aValidPulse : assert property (
      @(posedge clk) disable iff (rst)
      (vecValid && $past(vecValid)) |->
         (($past(devInta) != intaNone) && ($past(devInta, 2) != intaNone))
   )
   else
      $error("vector strobe held high without back-to-back acknowledges");

endmodule : ubaVectorLatch

/* src/ubaIrqTop.sv */
// Unibus adapter interrupt path top level
// Status register, interrupt block and vector latch wired together

`timescale 1ns/1ns

module ubaIrqTop
(
   input  logic                            clk,
   input  logic                            rst,
   // CPU status register access
   input  logic                            regWrite,
   input  logic [ubaPkg::regWidth-1:0]     regWdata,
   output logic [ubaPkg::regWidth-1:0]     regRdata,
   // Device requests and bus interrupt levels
   input  logic [ubaPkg::devCount-1:0]     devIntr,
   output logic [ubaPkg::busIntrWidth-1:0] busIntr,
   // WRU cycle and acknowledge
   input  logic                            wruRead,
   input  logic [ubaPkg::piWidth-1:0]      busPi,
   output logic [ubaPkg::devCount-1:0]     devInta,
   // Device vectors, lines 4..7
   input  logic [ubaPkg::vectorWidth-1:0]  devVector0,
   input  logic [ubaPkg::vectorWidth-1:0]  devVector1,
   input  logic [ubaPkg::vectorWidth-1:0]  devVector2,
   input  logic [ubaPkg::vectorWidth-1:0]  devVector3,
   // Vector out to the bus
   output logic [ubaPkg::vectorWidth-1:0]  vecData,
   output logic                            vecValid
);

   import ubaPkg::*;

   // Register to interrupt block
   logic [piWidth-1:0] piHigh;
   logic [piWidth-1:0] piLow;

   // Interrupt block back to the register
   logic intHi;
   logic intLo;

   //////////////////////////////////////////////////////////////////////
   // Status register
   //////////////////////////////////////////////////////////////////////

   ubaStatusReg statusReg0
   (
      .clk      (clk),
      .rst      (rst),
      .regWrite (regWrite),
      .regWdata (regWdata),
      .regRdata (regRdata),
      .intHi    (intHi),
      .intLo    (intLo),
      .piHigh   (piHigh),
      .piLow    (piLow)
   );

   //////////////////////////////////////////////////////////////////////
   // Interrupt request and WRU acknowledge
   //////////////////////////////////////////////////////////////////////

   ubaIntr intr0
   (
      .clk     (clk),
      .rst     (rst),
      .devIntr (devIntr),
      .piHigh  (piHigh),
      .piLow   (piLow),
      .intHi   (intHi),
      .intLo   (intLo),
      .busIntr (busIntr),
      .wruRead (wruRead),
      .busPi   (busPi),
      .devInta (devInta)
   );

   //////////////////////////////////////////////////////////////////////
   // Vector latch, one edge behind the acknowledge
   //////////////////////////////////////////////////////////////////////

   ubaVectorLatch vectorLatch0
   (
      .clk        (clk),
      .rst        (rst),
      .devInta    (devInta),
      .devVector0 (devVector0),
      .devVector1 (devVector1),
      .devVector2 (devVector2),
      .devVector3 (devVector3),
      .vecData    (vecData),
      .vecValid   (vecValid)
   );

endmodule : ubaIrqTop

/* tb/tbUbaModel.svh */
// Reference model for the Unibus adapter interrupt path
// Expected PI fields, bus levels, acknowledge and a two-entry vector pipeline

`ifndef TB_UBA_MODEL_SVH
`define TB_UBA_MODEL_SVH

// Expected stored PI levels
logic [piWidth-1:0]     mPiHigh;
logic [piWidth-1:0]     mPiLow;
// Entry one, acknowledge after the WRU edge
logic [devCount-1:0]    mInta;
// Entry two, vector strobe one edge later
logic                   mVecValid;
logic [vectorWidth-1:0] mVecData;

// Bus bit for one PI number, nothing for level 0
function automatic logic [busIntrWidth-1:0] levelBit(input logic [piWidth-1:0] level);
   logic [busIntrWidth-1:0] bits;
   bits = '0;
   if (level != 0)
      bits = 1 << (level - 1);
   return bits;
endfunction

// Each requesting group adds its level, groups ORed
function automatic logic [busIntrWidth-1:0] expectedBusIntr(
   input logic [devCount-1:0] req,
   input logic [piWidth-1:0]  piH,
   input logic [piWidth-1:0]  piL
);
   logic [busIntrWidth-1:0] lvl;
   lvl = '0;
   if (req[3] || req[2])
      lvl |= levelBit(piH);
   if (req[1] || req[0])
      lvl |= levelBit(piL);
   return lvl;
endfunction

// Upper byte zero, then INTHI, INTLO, high field, low field
function automatic logic [regWidth-1:0] expectedReadback(
   input logic [piWidth-1:0]  piH,
   input logic [piWidth-1:0]  piL,
   input logic [devCount-1:0] req
);
   return {8'h00, |req[3:2], |req[1:0], piH, piL};
endfunction

// High group checked first, higher line first within a group
function automatic logic [devCount-1:0] expectedAck(
   input logic                strobe,
   input logic [piWidth-1:0]  pi,
   input logic [devCount-1:0] req,
   input logic [piWidth-1:0]  piH,
   input logic [piWidth-1:0]  piL
);
   if (!strobe)
      return intaNone;
   if (pi == piH)
      return req[3] ? intaR7 : (req[2] ? intaR6 : intaNone);
   if (pi == piL)
      return req[1] ? intaR5 : (req[0] ? intaR4 : intaNone);
   return intaNone;
endfunction

// Vector of the acknowledged line, lines 4..7 map to vectors 0..3
function automatic logic [vectorWidth-1:0] pickVector(
   input logic [devCount-1:0]    ack,
   input logic [vectorWidth-1:0] v0,
   input logic [vectorWidth-1:0] v1,
   input logic [vectorWidth-1:0] v2,
   input logic [vectorWidth-1:0] v3
);
   case (ack)
      intaR7:  return v3;
      intaR6:  return v2;
      intaR5:  return v1;
      default: return v0;
   endcase
endfunction

task automatic modelReset();
   mPiHigh   = '0;
   mPiLow    = '0;
   mInta     = intaNone;
   mVecValid = 1'b0;
   mVecData  = '0;
endtask

// One rising edge, uses the inputs the DUT just sampled
task automatic modelEdge();
   // Entry two first, fed by the acknowledge of the edge before
   mVecValid = (mInta != intaNone);
   if (mVecValid)
      mVecData = pickVector(mInta, devVector0, devVector1, devVector2, devVector3);
   // Acknowledge decided on the old PI fields
   mInta = expectedAck(wruRead, busPi, devIntr, mPiHigh, mPiLow);
   // Field write lands on this same edge
   if (regWrite)
   begin
      mPiHigh = regWdata[pihLsb +: piWidth];
      mPiLow  = regWdata[pilLsb +: piWidth];
   end
endtask

`endif

/* tb/tbUbaIrq.sv */
// Testbench for the Unibus adapter interrupt path
// Random register, request and WRU traffic checked against a reference model

`timescale 1ns/1ns

module tbUbaIrq;

   import ubaPkg::*;

   // Cycles allowed for the vector strobe to show up
   localparam int vecTimeout   = 16;
   // Length of the random phase
   localparam int randomCycles = 500;

   logic                    clk;
   logic                    rst;
   logic                    regWrite;
   logic [regWidth-1:0]     regWdata;
   logic [regWidth-1:0]     regRdata;
   logic [devCount-1:0]     devIntr;
   logic [busIntrWidth-1:0] busIntr;
   logic                    wruRead;
   logic [piWidth-1:0]      busPi;
   logic [devCount-1:0]     devInta;
   logic [vectorWidth-1:0]  devVector0;
   logic [vectorWidth-1:0]  devVector1;
   logic [vectorWidth-1:0]  devVector2;
   logic [vectorWidth-1:0]  devVector3;
   logic [vectorWidth-1:0]  vecData;
   logic                    vecValid;
   integer                  seed;

   `include "tbUbaModel.svh"

   ubaIrqTop dut0
   (
      .clk        (clk),
      .rst        (rst),
      .regWrite   (regWrite),
      .regWdata   (regWdata),
      .regRdata   (regRdata),
      .devIntr    (devIntr),
      .busIntr    (busIntr),
      .wruRead    (wruRead),
      .busPi      (busPi),
      .devInta    (devInta),
      .devVector0 (devVector0),
      .devVector1 (devVector1),
      .devVector2 (devVector2),
      .devVector3 (devVector3),
      .vecData    (vecData),
      .vecValid   (vecValid)
   );

   // 4 ns period
   always #2 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reporting
   //////////////////////////////////////////////////////////////////////

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("Done: errors found");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkValue(input string testName, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (expected !== actual)
         failRun($sformatf("[FAIL] %s expected %0h actual %0h", testName, expected, actual));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Cycle stepping
   //////////////////////////////////////////////////////////////////////

   // Edge, model update, then the drive point 1 ns later
   task automatic advance();
      @(posedge clk);
      modelEdge();
      #1;
   endtask

   // Outputs compared mid-cycle where everything has settled
   task automatic settle(input string testName);
      #1;
      checkValue({testName, " busIntr"}, expectedBusIntr(devIntr, mPiHigh, mPiLow), busIntr);
      checkValue({testName, " regRdata"}, expectedReadback(mPiHigh, mPiLow, devIntr), regRdata);
      checkValue({testName, " devInta"}, mInta, devInta);
      checkValue({testName, " vecValid"}, mVecValid, vecValid);
      checkValue({testName, " vecData"}, mVecData, vecData);
   endtask

   task automatic randomInputs();
      logic [31:0]        r;
      logic [piWidth-1:0] piH;
      logic [piWidth-1:0] piL;
      r   = $random(seed);
      piH = $random(seed);
      // Equal levels about half the time
      if (r[7])
         piL = piH;
      else
         piL = $random(seed);
      regWrite = (r[2:0] == 3'd0);
      // Junk outside the PI fields must not stick
      regWdata = $random(seed);
      regWdata[pihLsb +: piWidth] = piH;
      regWdata[pilLsb +: piWidth] = piL;
      devIntr = $random(seed);
      // Dense strobes, lots of back-to-back WRU cycles
      wruRead = (r[4:3] != 2'd0);
      // Mostly serve a level that is actually in use
      case (r[6:5])
         2'd0:    busPi = mPiHigh;
         2'd1:    busPi = mPiLow;
         default: busPi = $random(seed);
      endcase
      devVector0 = $random(seed);
      devVector1 = $random(seed);
      devVector2 = $random(seed);
      devVector3 = $random(seed);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      int edges;
      seed       = 32'haf2;
      clk        = 1'b0;
      rst        = 1'b1;
      regWrite   = 1'b0;
      regWdata   = '0;
      devIntr    = '0;
      wruRead    = 1'b0;
      busPi      = '0;
      devVector0 = '0;
      devVector1 = '0;
      devVector2 = '0;
      devVector3 = '0;
      modelReset();

      // Reset over four cycles
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      #1;
      checkValue("reset busIntr", 0, busIntr);
      checkValue("reset devInta", intaNone, devInta);
      checkValue("reset vecValid", 0, vecValid);
      checkValue("reset regRdata", 0, regRdata);

      // Random traffic, every cycle compared with the model
      for (int i = 0; i < randomCycles; i++)
      begin
         advance();
         randomInputs();
         settle("random");
      end

      // Directed pair of WRU strobes, high then low group
      advance();
      regWrite   = 1'b1;
      regWdata   = (16'd5 << pihLsb) | (16'd3 << pilLsb);
      devIntr    = 4'b1111;
      wruRead    = 1'b0;
      devVector0 = $random(seed);
      devVector1 = $random(seed);
      devVector2 = $random(seed);
      devVector3 = $random(seed);
      settle("directed setup");
      advance();
      regWrite = 1'b0;
      wruRead  = 1'b1;
      busPi    = 3'd5;
      settle("directed wru high");
      advance();
      busPi = 3'd3;
      settle("directed wru low");

      // Count edges from the first strobe up to its vector
      edges = 1;
      while (!vecValid && edges < vecTimeout)
      begin
         advance();
         wruRead = 1'b0;
         settle("vector wait");
         edges++;
      end
      if (!vecValid)
         failRun("Vector strobe never came after the WRU acknowledge");
      checkValue("wru to vector latency", 2, edges);
      checkValue("first vector", devVector3, vecData);

      // Second strobe right behind the first
      advance();
      settle("second vector");
      checkValue("second vector valid", 1, vecValid);
      checkValue("second vector data", devVector1, vecData);

      // Strobe drops, data holds
      advance();
      settle("vector hold");
      checkValue("vector hold valid", 0, vecValid);
      checkValue("vector hold data", devVector1, vecData);

      $display("Done: no errors");
      $finish;
   end

endmodule : tbUbaIrq

/* all.f */
+incdir+tb
src/ubaPkg.sv
src/ubaStatusReg.sv
src/ubaIntr.sv
src/ubaVectorLatch.sv
src/ubaIrqTop.sv
tb/tbUbaIrq.sv

/* Bender.yml */
package:
  name: uba_irq

sources:
  - files:
      - src/ubaPkg.sv
      - src/ubaStatusReg.sv
      - src/ubaIntr.sv
      - src/ubaVectorLatch.sv
      - src/ubaIrqTop.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbUbaIrq.sv
